// ==== src/lsq_cfg.svh ====
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// Queue capacities
`define LSQ_SQ_CAPACITY 8
`define LSQ_LB_CAPACITY 4

// Index widths, log2 of the capacities
`define LSQ_SQ_IDX_W 3
`define LSQ_LB_IDX_W 2

// Address and data width
`define LSQ_XLEN 32

// Destination tag carried by a load
`define LSQ_TAG_W 6

`endif

// ==== src/lsq_mem_pkg.sv ====
`default_nettype none
`include "lsq_cfg.svh"

package lsq_mem_pkg;

    // Access size, log2 of the byte count
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    // One store data word, read either as bytes or as halves
    typedef union packed {
        logic [`LSQ_XLEN/8-1:0][7:0]   bytes;
        logic [`LSQ_XLEN/16-1:0][15:0] halves;
    } store_word_u;

endpackage

`default_nettype wire

// ==== src/lsq_queue_pkg.sv ====
`default_nettype none
`include "lsq_cfg.svh"

package lsq_queue_pkg;

    // Store queue slot, also the age stamp of a load
    typedef logic [`LSQ_SQ_IDX_W-1:0] sq_idx_t;

    // Load buffer slot
    typedef logic [`LSQ_LB_IDX_W-1:0] lb_idx_t;

    // How the forwarding unit serves a load
    typedef enum logic [1:0] {
        LOAD_FORWARD  = 2'd0,
        LOAD_TO_CACHE = 2'd1,
        LOAD_BLOCKED  = 2'd2
    } load_outcome_t;

endpackage

`default_nettype wire

// ==== src/store_queue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsq_cfg.svh"

module store_queue (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          sq_alloc,
    input  logic                                          sq_resolve_valid,
    input  lsq_queue_pkg::sq_idx_t                        sq_resolve_idx,
    input  logic [`LSQ_XLEN-1:0]                          sq_resolve_base,
    input  logic [`LSQ_XLEN-1:0]                          sq_resolve_offset,
    input  logic [`LSQ_XLEN-1:0]                          sq_resolve_data,
    input  lsq_mem_pkg::mem_size_t                        sq_resolve_size,
    input  logic                                          store_commit,
    output logic                                          sq_full,
    output lsq_queue_pkg::sq_idx_t                        sq_tail,
    output lsq_queue_pkg::sq_idx_t                        sq_head,
    output logic                                          sq_head_resolved,
    output logic [`LSQ_SQ_CAPACITY-1:0][`LSQ_XLEN-1:0]    slot_addr,
    output logic [`LSQ_SQ_CAPACITY-1:0][`LSQ_XLEN-1:0]    slot_data,
    output lsq_mem_pkg::mem_size_t [`LSQ_SQ_CAPACITY-1:0] slot_size,
    output logic [`LSQ_SQ_CAPACITY-1:0]                   slot_resolved,
    output lsq_queue_pkg::sq_idx_t                        secure_age,
    output logic                                          all_resolved,
    output logic                                          cache_store_valid,
    output logic [`LSQ_XLEN-1:0]                          cache_store_addr,
    output logic [`LSQ_XLEN-1:0]                          cache_store_data,
    output lsq_mem_pkg::mem_size_t                        cache_store_size
);

    import lsq_queue_pkg::*;

    logic [`LSQ_SQ_IDX_W:0] count;
    logic                   do_alloc;
    logic                   do_retire;
    sq_idx_t                oldest_idx;
    logic                   oldest_found;

    assign sq_full          = (count == (`LSQ_SQ_IDX_W+1)'(`LSQ_SQ_CAPACITY));
    assign sq_head_resolved = slot_resolved[sq_head];
    assign do_alloc         = sq_alloc && !sq_full;
    assign do_retire        = store_commit && sq_head_resolved;

    //////////////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge clock) begin
        if (reset) begin
            sq_head <= '0;
            sq_tail <= '0;
            count   <= '0;
        end else begin
            if (do_alloc) begin
                sq_tail <= sq_tail + 1'b1;
            end
            if (do_retire) begin
                sq_head <= sq_head + 1'b1;
            end
            case ({do_alloc, do_retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A new slot starts unresolved, a retired one is cleared
    always_ff @(posedge clock) begin
        if (reset) begin
            slot_resolved <= '0;
        end else begin
            if (do_alloc) begin
                slot_resolved[sq_tail] <= 1'b0;
            end
            if (sq_resolve_valid) begin
                slot_resolved[sq_resolve_idx] <= 1'b1;
            end
            if (do_retire) begin
                slot_resolved[sq_head] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sq_resolve_valid) begin
            slot_addr[sq_resolve_idx] <= sq_resolve_base + sq_resolve_offset;
            slot_data[sq_resolve_idx] <= sq_resolve_data;
            slot_size[sq_resolve_idx] <= sq_resolve_size;
        end
    end

    //////////////////////////////////////////////////
    // Oldest unresolved store, walked from the head

    always_comb begin
        sq_idx_t scan_idx;
        oldest_idx   = sq_tail;
        oldest_found = 1'b0;
        for (int i = 0; i < `LSQ_SQ_CAPACITY; i++) begin
            scan_idx = sq_head + sq_idx_t'(i);
            if (!oldest_found && (i < int'(count)) && !slot_resolved[scan_idx]) begin
                oldest_idx   = scan_idx;
                oldest_found = 1'b1;
            end
        end
    end

    // Empty queue counts as all resolved
    always_ff @(posedge clock) begin
        if (reset) begin
            secure_age   <= '0;
            all_resolved <= 1'b1;
        end else begin
            secure_age   <= oldest_idx;
            all_resolved <= !oldest_found;
        end
    end

    //////////////////////////////////////////////////
    // Retired head goes out to the data cache

    always_ff @(posedge clock) begin
        if (reset) begin
            cache_store_valid <= 1'b0;
        end else begin
            cache_store_valid <= do_retire;
        end
    end

    always_ff @(posedge clock) begin
        if (do_retire) begin
            cache_store_addr <= slot_addr[sq_head];
            cache_store_data <= slot_data[sq_head];
            cache_store_size <= slot_size[sq_head];
        end
    end

endmodule

`default_nettype wire

// ==== src/load_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsq_cfg.svh"

module load_buffer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   lb_alloc,
    input  lsq_queue_pkg::sq_idx_t sq_tail,
    input  lsq_queue_pkg::sq_idx_t sq_head,
    input  lsq_queue_pkg::sq_idx_t secure_age,
    input  logic                   all_resolved,
    input  logic                   lb_resolve_valid,
    input  lsq_queue_pkg::lb_idx_t lb_resolve_idx,
    input  logic [`LSQ_XLEN-1:0]   lb_resolve_base,
    input  logic [`LSQ_XLEN-1:0]   lb_resolve_offset,
    input  lsq_mem_pkg::mem_size_t lb_resolve_size,
    input  logic                   lb_resolve_signed,
    input  logic [`LSQ_TAG_W-1:0]  lb_resolve_tag,
    input  logic                   candidate_taken,
    output logic                   lb_full,
    output lsq_queue_pkg::lb_idx_t lb_alloc_idx,
    output logic                   candidate_valid,
    output logic [`LSQ_XLEN-1:0]   candidate_addr,
    output lsq_mem_pkg::mem_size_t candidate_size,
    output logic                   candidate_signed,
    output logic [`LSQ_TAG_W-1:0]  candidate_tag,
    output lsq_queue_pkg::sq_idx_t candidate_age
);

    import lsq_mem_pkg::*;
    import lsq_queue_pkg::*;

    logic [`LSQ_LB_CAPACITY-1:0] slot_busy;
    logic [`LSQ_LB_CAPACITY-1:0] slot_resolved;
    logic [`LSQ_LB_CAPACITY-1:0] slot_eligible;
    sq_idx_t                     slot_age    [`LSQ_LB_CAPACITY];
    logic [`LSQ_XLEN-1:0]        slot_addr   [`LSQ_LB_CAPACITY];
    mem_size_t                   slot_size   [`LSQ_LB_CAPACITY];
    logic                        slot_signed [`LSQ_LB_CAPACITY];
    logic [`LSQ_TAG_W-1:0]       slot_tag    [`LSQ_LB_CAPACITY];
    lb_idx_t                     cand_idx;
    sq_idx_t                     secure_dist;
    logic                        do_alloc;

    assign lb_full     = &slot_busy;
    assign do_alloc    = lb_alloc && !lb_full;
    assign secure_dist = secure_age - sq_head;

    // Lowest free slot takes the next load
    always_comb begin
        lb_alloc_idx = '0;
        for (int i = `LSQ_LB_CAPACITY-1; i >= 0; i--) begin
            if (!slot_busy[i]) begin
                lb_alloc_idx = lb_idx_t'(i);
            end
        end
    end

    // Age between head and the oldest unresolved store, that store included,
    // means every older store already has its address
    always_comb begin
        for (int i = 0; i < `LSQ_LB_CAPACITY; i++) begin
            slot_eligible[i] = slot_busy[i] && slot_resolved[i] &&
                               (all_resolved ||
                                (sq_idx_t'(slot_age[i] - sq_head) <= secure_dist));
        end
    end

    // Fixed priority, lowest index first
    always_comb begin
        cand_idx = '0;
        for (int i = `LSQ_LB_CAPACITY-1; i >= 0; i--) begin
            if (slot_eligible[i]) begin
                cand_idx = lb_idx_t'(i);
            end
        end
    end

    assign candidate_valid  = |slot_eligible;
    assign candidate_addr   = slot_addr[cand_idx];
    assign candidate_size   = slot_size[cand_idx];
    assign candidate_signed = slot_signed[cand_idx];
    assign candidate_tag    = slot_tag[cand_idx];
    assign candidate_age    = slot_age[cand_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            slot_busy     <= '0;
            slot_resolved <= '0;
        end else begin
            if (do_alloc) begin
                slot_busy[lb_alloc_idx]     <= 1'b1;
                slot_resolved[lb_alloc_idx] <= 1'b0;
            end
            if (lb_resolve_valid) begin
                slot_resolved[lb_resolve_idx] <= 1'b1;
            end
            // Served load leaves its slot
            if (candidate_taken) begin
                slot_busy[cand_idx]     <= 1'b0;
                slot_resolved[cand_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_alloc) begin
            slot_age[lb_alloc_idx] <= sq_tail;
        end
        if (lb_resolve_valid) begin
            slot_addr[lb_resolve_idx]   <= lb_resolve_base + lb_resolve_offset;
            slot_size[lb_resolve_idx]   <= lb_resolve_size;
            slot_signed[lb_resolve_idx] <= lb_resolve_signed;
            slot_tag[lb_resolve_idx]    <= lb_resolve_tag;
        end
    end

endmodule

`default_nettype wire

// ==== src/load_forward.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsq_cfg.svh"

module load_forward (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          candidate_valid,
    input  logic [`LSQ_XLEN-1:0]                          candidate_addr,
    input  lsq_mem_pkg::mem_size_t                        candidate_size,
    input  logic                                          candidate_signed,
    input  logic [`LSQ_TAG_W-1:0]                         candidate_tag,
    input  lsq_queue_pkg::sq_idx_t                        candidate_age,
    input  lsq_queue_pkg::sq_idx_t                        sq_head,
    input  logic [`LSQ_SQ_CAPACITY-1:0][`LSQ_XLEN-1:0]    slot_addr,
    input  logic [`LSQ_SQ_CAPACITY-1:0][`LSQ_XLEN-1:0]    slot_data,
    input  lsq_mem_pkg::mem_size_t [`LSQ_SQ_CAPACITY-1:0] slot_size,
    input  logic [`LSQ_SQ_CAPACITY-1:0]                   slot_resolved,
    output logic                                          candidate_taken,
    output logic                                          fwd_valid,
    output logic [`LSQ_XLEN-1:0]                          fwd_data,
    output logic [`LSQ_TAG_W-1:0]                         fwd_tag,
    output logic                                          cache_load_valid,
    output logic [`LSQ_XLEN-1:0]                          cache_load_addr,
    output lsq_mem_pkg::mem_size_t                        cache_load_size,
    output logic                                          cache_load_signed,
    output logic [`LSQ_TAG_W-1:0]                         cache_load_tag
);

    import lsq_mem_pkg::*;
    import lsq_queue_pkg::*;

    logic [3:0]           load_mask;
    logic                 hit;
    logic                 hit_covers;
    sq_idx_t              hit_idx;
    sq_idx_t              older_cnt;
    load_outcome_t        outcome;
    store_word_u          hit_word;
    logic [1:0]           lane;
    logic [`LSQ_XLEN-1:0] load_data;

    // Bytes touched within the aligned word
    function automatic logic [3:0] byte_mask(input mem_size_t size, input logic [1:0] offs);
        case (size)
            MEM_BYTE: byte_mask = 4'b0001 << offs;
            MEM_HALF: byte_mask = 4'b0011 << {offs[1], 1'b0};
            default:  byte_mask = 4'b1111;
        endcase
    endfunction

    assign older_cnt = candidate_age - sq_head;
    assign load_mask = byte_mask(candidate_size, candidate_addr[1:0]);

    //////////////////////////////////////////////////
    // Youngest older store touching the load's bytes

    always_comb begin
        sq_idx_t    scan_idx;
        logic [3:0] store_mask;
        hit        = 1'b0;
        hit_covers = 1'b0;
        hit_idx    = sq_head;
        for (int i = 0; i < `LSQ_SQ_CAPACITY; i++) begin
            scan_idx   = sq_head + sq_idx_t'(i);
            store_mask = byte_mask(slot_size[scan_idx], slot_addr[scan_idx][1:0]);
            if ((sq_idx_t'(i) < older_cnt) && slot_resolved[scan_idx] &&
                (slot_addr[scan_idx][`LSQ_XLEN-1:2] == candidate_addr[`LSQ_XLEN-1:2]) &&
                (|(store_mask & load_mask))) begin
                hit        = 1'b1;
                hit_covers = ((load_mask & ~store_mask) == 4'b0000);
                hit_idx    = scan_idx;
            end
        end
    end

    always_comb begin
        if (!hit) begin
            outcome = LOAD_TO_CACHE;
        end else if (hit_covers) begin
            outcome = LOAD_FORWARD;
        end else begin
            outcome = LOAD_BLOCKED;
        end
    end

    // A partly covered load stays put until the store drains
    assign candidate_taken = candidate_valid && (outcome != LOAD_BLOCKED);

    //////////////////////////////////////////////////
    // Forwarded data

    // Store data sits in the low lanes, so offset by the store's own address
    assign hit_word = slot_data[hit_idx];
    assign lane     = candidate_addr[1:0] - slot_addr[hit_idx][1:0];

    always_comb begin
        case (candidate_size)
            MEM_BYTE: begin
                load_data = {{24{candidate_signed & hit_word.bytes[lane][7]}},
                             hit_word.bytes[lane]};
            end
            MEM_HALF: begin
                load_data = {{16{candidate_signed & hit_word.halves[lane[1]][15]}},
                             hit_word.halves[lane[1]]};
            end
            default: load_data = hit_word;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fwd_valid        <= 1'b0;
            cache_load_valid <= 1'b0;
        end else begin
            fwd_valid        <= candidate_valid && (outcome == LOAD_FORWARD);
            cache_load_valid <= candidate_valid && (outcome == LOAD_TO_CACHE);
        end
    end

    always_ff @(posedge clock) begin
        if (candidate_taken) begin
            fwd_data          <= load_data;
            fwd_tag           <= candidate_tag;
            cache_load_addr   <= candidate_addr;
            cache_load_size   <= candidate_size;
            cache_load_signed <= candidate_signed;
            cache_load_tag    <= candidate_tag;
        end
    end

endmodule

`default_nettype wire

// ==== src/load_store_queue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsq_cfg.svh"

module load_store_queue (
    input  logic                   clock,
    input  logic                   reset,
    // Store side
    input  logic                   sq_alloc,
    input  logic                   sq_resolve_valid,
    input  lsq_queue_pkg::sq_idx_t sq_resolve_idx,
    input  logic [`LSQ_XLEN-1:0]   sq_resolve_base,
    input  logic [`LSQ_XLEN-1:0]   sq_resolve_offset,
    input  logic [`LSQ_XLEN-1:0]   sq_resolve_data,
    input  lsq_mem_pkg::mem_size_t sq_resolve_size,
    input  logic                   store_commit,
    output logic                   sq_full,
    output lsq_queue_pkg::sq_idx_t sq_tail,
    output lsq_queue_pkg::sq_idx_t sq_head,
    output logic                   sq_head_resolved,
    output logic                   cache_store_valid,
    output logic [`LSQ_XLEN-1:0]   cache_store_addr,
    output logic [`LSQ_XLEN-1:0]   cache_store_data,
    output lsq_mem_pkg::mem_size_t cache_store_size,
    // Load side
    input  logic                   lb_alloc,
    input  logic                   lb_resolve_valid,
    input  lsq_queue_pkg::lb_idx_t lb_resolve_idx,
    input  logic [`LSQ_XLEN-1:0]   lb_resolve_base,
    input  logic [`LSQ_XLEN-1:0]   lb_resolve_offset,
    input  lsq_mem_pkg::mem_size_t lb_resolve_size,
    input  logic                   lb_resolve_signed,
    input  logic [`LSQ_TAG_W-1:0]  lb_resolve_tag,
    output logic                   lb_full,
    output lsq_queue_pkg::lb_idx_t lb_alloc_idx,
    output logic                   fwd_valid,
    output logic [`LSQ_XLEN-1:0]   fwd_data,
    output logic [`LSQ_TAG_W-1:0]  fwd_tag,
    output logic                   cache_load_valid,
    output logic [`LSQ_XLEN-1:0]   cache_load_addr,
    output lsq_mem_pkg::mem_size_t cache_load_size,
    output logic                   cache_load_signed,
    output logic [`LSQ_TAG_W-1:0]  cache_load_tag
);

    import lsq_mem_pkg::*;
    import lsq_queue_pkg::*;

    // Store slot view shared with the forwarding unit
    logic [`LSQ_SQ_CAPACITY-1:0][`LSQ_XLEN-1:0] slot_addr;
    logic [`LSQ_SQ_CAPACITY-1:0][`LSQ_XLEN-1:0] slot_data;
    mem_size_t [`LSQ_SQ_CAPACITY-1:0]           slot_size;
    logic [`LSQ_SQ_CAPACITY-1:0]                slot_resolved;
    sq_idx_t                                    secure_age;
    logic                                       all_resolved;

    // Candidate load
    logic                  candidate_valid;
    logic [`LSQ_XLEN-1:0]  candidate_addr;
    mem_size_t             candidate_size;
    logic                  candidate_signed;
    logic [`LSQ_TAG_W-1:0] candidate_tag;
    sq_idx_t               candidate_age;
    logic                  candidate_taken;

    store_queue store_queue0 (
        .clock, .reset, .sq_alloc, .sq_resolve_valid, .sq_resolve_idx,
        .sq_resolve_base, .sq_resolve_offset, .sq_resolve_data, .sq_resolve_size,
        .store_commit, .sq_full, .sq_tail, .sq_head, .sq_head_resolved,
        .slot_addr, .slot_data, .slot_size, .slot_resolved, .secure_age, .all_resolved,
        .cache_store_valid, .cache_store_addr, .cache_store_data, .cache_store_size
    );

    load_buffer load_buffer0 (
        .clock, .reset, .lb_alloc, .sq_tail, .sq_head, .secure_age, .all_resolved,
        .lb_resolve_valid, .lb_resolve_idx, .lb_resolve_base, .lb_resolve_offset,
        .lb_resolve_size, .lb_resolve_signed, .lb_resolve_tag, .candidate_taken,
        .lb_full, .lb_alloc_idx, .candidate_valid, .candidate_addr, .candidate_size,
        .candidate_signed, .candidate_tag, .candidate_age
    );

    load_forward load_forward0 (
        .clock, .reset, .candidate_valid, .candidate_addr, .candidate_size,
        .candidate_signed, .candidate_tag, .candidate_age, .sq_head,
        .slot_addr, .slot_data, .slot_size, .slot_resolved, .candidate_taken,
        .fwd_valid, .fwd_data, .fwd_tag, .cache_load_valid, .cache_load_addr,
        .cache_load_size, .cache_load_signed, .cache_load_tag
    );

endmodule

`default_nettype wire

// ==== verif/lsq_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_clock_gen (
    output logic clock
);

    localparam time HALF_PERIOD = 4ns;

    // 8 ns period, starts low
    initial begin
        clock = 1'b0;
    end

    always #(HALF_PERIOD) clock = ~clock;

endmodule

`default_nettype wire

// ==== verif/lsq_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsq_cfg.svh"

module lsq_tb;

    import lsq_mem_pkg::*;
    import lsq_queue_pkg::*;

    localparam int WAIT_LIMIT = 50;

    logic                  clock;
    logic                  reset;
    logic                  sq_alloc;
    logic                  sq_resolve_valid;
    sq_idx_t               sq_resolve_idx;
    logic [`LSQ_XLEN-1:0]  sq_resolve_base;
    logic [`LSQ_XLEN-1:0]  sq_resolve_offset;
    logic [`LSQ_XLEN-1:0]  sq_resolve_data;
    mem_size_t             sq_resolve_size;
    logic                  store_commit;
    logic                  sq_full;
    sq_idx_t               sq_tail;
    sq_idx_t               sq_head;
    logic                  sq_head_resolved;
    logic                  cache_store_valid;
    logic [`LSQ_XLEN-1:0]  cache_store_addr;
    logic [`LSQ_XLEN-1:0]  cache_store_data;
    mem_size_t             cache_store_size;
    logic                  lb_alloc;
    logic                  lb_resolve_valid;
    lb_idx_t               lb_resolve_idx;
    logic [`LSQ_XLEN-1:0]  lb_resolve_base;
    logic [`LSQ_XLEN-1:0]  lb_resolve_offset;
    mem_size_t             lb_resolve_size;
    logic                  lb_resolve_signed;
    logic [`LSQ_TAG_W-1:0] lb_resolve_tag;
    logic                  lb_full;
    lb_idx_t               lb_alloc_idx;
    logic                  fwd_valid;
    logic [`LSQ_XLEN-1:0]  fwd_data;
    logic [`LSQ_TAG_W-1:0] fwd_tag;
    logic                  cache_load_valid;
    logic [`LSQ_XLEN-1:0]  cache_load_addr;
    mem_size_t             cache_load_size;
    logic                  cache_load_signed;
    logic [`LSQ_TAG_W-1:0] cache_load_tag;

    integer seed;

    lsq_clock_gen clock_gen0 (
        .clock
    );

    load_store_queue dut0 (
        .clock, .reset, .sq_alloc, .sq_resolve_valid, .sq_resolve_idx,
        .sq_resolve_base, .sq_resolve_offset, .sq_resolve_data, .sq_resolve_size,
        .store_commit, .sq_full, .sq_tail, .sq_head, .sq_head_resolved,
        .cache_store_valid, .cache_store_addr, .cache_store_data, .cache_store_size,
        .lb_alloc, .lb_resolve_valid, .lb_resolve_idx, .lb_resolve_base,
        .lb_resolve_offset, .lb_resolve_size, .lb_resolve_signed, .lb_resolve_tag,
        .lb_full, .lb_alloc_idx, .fwd_valid, .fwd_data, .fwd_tag,
        .cache_load_valid, .cache_load_addr, .cache_load_size, .cache_load_signed,
        .cache_load_tag
    );

    //////////////////////////////////////////////////
    // Checking and stepping

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with($sformatf("Fail %s: got 0x%08h, expected 0x%08h",
                                name, actual, expected));
        end
    endtask

    // Inputs change and outputs are read 1 ns after the edge
    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    // Word aligned offset within a 1 KB window
    function automatic logic [31:0] random_word_offset();
        return {$random(seed)} & 32'h0000_03FC;
    endfunction

    //////////////////////////////////////////////////
    // Bus actions

    task automatic alloc_store(output sq_idx_t idx);
        idx      = sq_tail;
        sq_alloc = 1'b1;
        tick();
        sq_alloc = 1'b0;
    endtask

    task automatic resolve_store(input sq_idx_t idx, input logic [31:0] base,
                                 input logic [31:0] offs, input logic [31:0] data,
                                 input mem_size_t size);
        sq_resolve_valid  = 1'b1;
        sq_resolve_idx    = idx;
        sq_resolve_base   = base;
        sq_resolve_offset = offs;
        sq_resolve_data   = data;
        sq_resolve_size   = size;
        tick();
        sq_resolve_valid  = 1'b0;
    endtask

    // Returns in the cycle after the strobe when the cache store shows up
    task automatic commit_store();
        store_commit = 1'b1;
        tick();
        store_commit = 1'b0;
    endtask

    task automatic alloc_load(output lb_idx_t slot);
        slot     = lb_alloc_idx;
        lb_alloc = 1'b1;
        tick();
        lb_alloc = 1'b0;
    endtask

    task automatic resolve_load(input lb_idx_t slot, input logic [31:0] base,
                                input logic [31:0] offs, input mem_size_t size,
                                input logic is_signed, input logic [5:0] tag);
        lb_resolve_valid  = 1'b1;
        lb_resolve_idx    = slot;
        lb_resolve_base   = base;
        lb_resolve_offset = offs;
        lb_resolve_size   = size;
        lb_resolve_signed = is_signed;
        lb_resolve_tag    = tag;
        tick();
        lb_resolve_valid  = 1'b0;
    endtask

    task automatic wait_head_resolved();
        int cycles;
        cycles = 0;
        while (!sq_head_resolved) begin
            if (cycles == WAIT_LIMIT) begin
                stop_with("Timed out waiting for the store queue head to resolve");
            end
            tick();
            cycles++;
        end
    endtask

    task automatic wait_load_result();
        int cycles;
        cycles = 0;
        while (!fwd_valid && !cache_load_valid) begin
            if (cycles == WAIT_LIMIT) begin
                stop_with("Timed out waiting for a load to be forwarded or sent to the cache");
            end
            tick();
            cycles++;
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            tick();
            if (fwd_valid || cache_load_valid) begin
                stop_with("A load produced an output while it still had to wait");
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic check_reset_state();
        check_value("sq_full", sq_full, 0);
        check_value("lb_full", lb_full, 0);
        check_value("fwd_valid", fwd_valid, 0);
        check_value("cache_load_valid", cache_load_valid, 0);
        check_value("cache_store_valid", cache_store_valid, 0);
        check_value("sq_tail", sq_tail, 0);
    endtask

    task automatic commit_to_cache();
        sq_idx_t     idx;
        logic [31:0] base;
        logic [31:0] offs;
        base = 32'h0000_4000;
        offs = random_word_offset();
        alloc_store(idx);
        resolve_store(idx, base, offs, 32'hCAFE_F00D, MEM_WORD);
        wait_head_resolved();
        commit_store();
        check_value("cache_store_valid", cache_store_valid, 1);
        check_value("cache_store_addr", cache_store_addr, base + offs);
        check_value("cache_store_data", cache_store_data, 32'hCAFE_F00D);
        check_value("cache_store_size", cache_store_size, MEM_WORD);
        // Head not resolved, so the commit is dropped
        alloc_store(idx);
        check_value("sq_head_resolved", sq_head_resolved, 0);
        commit_store();
        check_value("cache_store_valid", cache_store_valid, 0);
        check_value("sq_head", sq_head, idx);
        resolve_store(idx, base, offs + 32'd5, 32'h0000_00A5, MEM_BYTE);
        wait_head_resolved();
        commit_store();
        check_value("cache_store_valid", cache_store_valid, 1);
        check_value("cache_store_addr", cache_store_addr, base + offs + 32'd5);
        check_value("cache_store_size", cache_store_size, MEM_BYTE);
    endtask

    task automatic load_misses_queue();
        lb_idx_t     slot;
        logic [31:0] offs;
        offs = random_word_offset();
        alloc_load(slot);
        resolve_load(slot, 32'h0000_2000, offs, MEM_HALF, 1'b1, 6'h15);
        wait_load_result();
        check_value("fwd_valid", fwd_valid, 0);
        check_value("cache_load_valid", cache_load_valid, 1);
        check_value("cache_load_addr", cache_load_addr, 32'h0000_2000 + offs);
        check_value("cache_load_size", cache_load_size, MEM_HALF);
        check_value("cache_load_signed", cache_load_signed, 1);
        check_value("cache_load_tag", cache_load_tag, 6'h15);
    endtask

    task automatic forward_from_store();
        sq_idx_t     idx;
        lb_idx_t     slot;
        logic [31:0] addr;
        addr = 32'h0000_6000 + random_word_offset();
        alloc_store(idx);
        resolve_store(idx, addr, 32'd0, 32'h80FF_1234, MEM_WORD);
        // Top byte with sign extension
        alloc_load(slot);
        resolve_load(slot, addr, 32'd3, MEM_BYTE, 1'b1, 6'h21);
        wait_load_result();
        check_value("cache_load_valid", cache_load_valid, 0);
        check_value("fwd_valid", fwd_valid, 1);
        check_value("fwd_data", fwd_data, 32'hFFFF_FF80);
        check_value("fwd_tag", fwd_tag, 6'h21);
        // Upper half with zero extension
        alloc_load(slot);
        resolve_load(slot, addr, 32'd2, MEM_HALF, 1'b0, 6'h22);
        wait_load_result();
        check_value("cache_load_valid", cache_load_valid, 0);
        check_value("fwd_data", fwd_data, 32'h0000_80FF);
        check_value("fwd_tag", fwd_tag, 6'h22);
        commit_store();
        check_value("cache_store_valid", cache_store_valid, 1);
    endtask

    task automatic order_behind_stores();
        sq_idx_t     idx;
        lb_idx_t     slot;
        logic [31:0] offs;
        logic [31:0] addr;
        // Older store with no address yet
        offs = random_word_offset();
        alloc_store(idx);
        alloc_load(slot);
        resolve_load(slot, 32'h0000_2000, offs, MEM_WORD, 1'b0, 6'h31);
        expect_quiet(10);
        resolve_store(idx, 32'h0000_3000, offs, 32'h1111_2222, MEM_WORD);
        wait_load_result();
        check_value("fwd_valid", fwd_valid, 0);
        check_value("cache_load_addr", cache_load_addr, 32'h0000_2000 + offs);
        check_value("cache_load_tag", cache_load_tag, 6'h31);
        commit_store();
        check_value("cache_store_valid", cache_store_valid, 1);
        // Older byte store covering only part of a word load
        addr = 32'h0000_5000 + random_word_offset();
        alloc_store(idx);
        resolve_store(idx, addr, 32'd1, 32'h0000_00EE, MEM_BYTE);
        alloc_load(slot);
        resolve_load(slot, addr, 32'd0, MEM_WORD, 1'b0, 6'h32);
        expect_quiet(10);
        commit_store();
        check_value("cache_store_valid", cache_store_valid, 1);
        wait_load_result();
        check_value("fwd_valid", fwd_valid, 0);
        check_value("cache_load_addr", cache_load_addr, addr);
        check_value("cache_load_tag", cache_load_tag, 6'h32);
    endtask

    task automatic fill_both_queues();
        sq_idx_t idx;
        sq_idx_t start;
        lb_idx_t slot;
        start = sq_tail;
        for (int i = 0; i < `LSQ_SQ_CAPACITY; i++) begin
            check_value("sq_full", sq_full, 0);
            alloc_store(idx);
        end
        check_value("sq_full", sq_full, 1);
        check_value("sq_tail", sq_tail, start);
        // Allocation on a full queue is dropped
        alloc_store(idx);
        check_value("sq_tail", sq_tail, start);
        for (int i = 0; i < `LSQ_LB_CAPACITY; i++) begin
            check_value("lb_full", lb_full, 0);
            check_value("lb_alloc_idx", lb_alloc_idx, i);
            alloc_load(slot);
        end
        check_value("lb_full", lb_full, 1);
        resolve_store(sq_head, 32'h0000_7000, 32'd0, 32'h0BAD_CAFE, MEM_WORD);
        wait_head_resolved();
        commit_store();
        check_value("cache_store_valid", cache_store_valid, 1);
        check_value("sq_full", sq_full, 0);
    endtask

    //////////////////////////////////////////////////
    // Sequence

    initial begin
        seed              = 32'h4280;
        reset             = 1'b1;
        sq_alloc          = 1'b0;
        sq_resolve_valid  = 1'b0;
        sq_resolve_idx    = '0;
        sq_resolve_base   = '0;
        sq_resolve_offset = '0;
        sq_resolve_data   = '0;
        sq_resolve_size   = MEM_BYTE;
        store_commit      = 1'b0;
        lb_alloc          = 1'b0;
        lb_resolve_valid  = 1'b0;
        lb_resolve_idx    = '0;
        lb_resolve_base   = '0;
        lb_resolve_offset = '0;
        lb_resolve_size   = MEM_BYTE;
        lb_resolve_signed = 1'b0;
        lb_resolve_tag    = '0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        check_reset_state();
        commit_to_cache();
        load_misses_queue();
        forward_from_store();
        order_behind_stores();
        fill_both_queues();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/lsq_mem_pkg.sv
src/lsq_queue_pkg.sv
src/store_queue.sv
src/load_buffer.sv
src/load_forward.sv
src/load_store_queue.sv
verif/lsq_clock_gen.sv
verif/lsq_tb.sv
